// File: logic/kalmanPkg.sv
package kalmanPkg;

    ////////////////////////////////////////////////////////////
    // Model sizes and widths
    ////////////////////////////////////////////////////////////

    localparam int stateCount   = 6;
    localparam int axisCount    = 3;
    localparam int matrixSize   = stateCount * stateCount;

    localparam int inWidth      = 16;
    localparam int productWidth = 24;
    localparam int outWidth     = 32;

    ////////////////////////////////////////////////////////////
    // Constant-velocity model
    ////////////////////////////////////////////////////////////

    localparam int timeStep    = 1;
    localparam int posVariance = 1;
    localparam int velVariance = 10;

    // Velocity term i+3 feeds position term i
    localparam int transitionMatrix [stateCount][stateCount] = '{
        '{1, 0, 0, timeStep, 0,        0       },
        '{0, 1, 0, 0,        timeStep, 0       },
        '{0, 0, 1, 0,        0,        timeStep},
        '{0, 0, 0, 1,        0,        0       },
        '{0, 0, 0, 0,        1,        0       },
        '{0, 0, 0, 0,        0,        1       }
    };

    ////////////////////////////////////////////////////////////
    // Element and array types
    ////////////////////////////////////////////////////////////

    typedef logic signed [inWidth-1:0]      inElem_t;
    typedef logic signed [productWidth-1:0] productElem_t;
    typedef logic signed [outWidth-1:0]     outElem_t;

    typedef inElem_t [stateCount-1:0] inVector_t;
    // Row-major, element (r, c) at r * stateCount + c
    typedef inElem_t      [matrixSize-1:0] inMatrix_t;
    typedef productElem_t [matrixSize-1:0] productMatrix_t;

    typedef outElem_t [stateCount-1:0] outVector_t;
    typedef outElem_t [matrixSize-1:0] outMatrix_t;

    // Stage payloads
    typedef struct packed {
        outVector_t     state;
        productMatrix_t cov;
    } midPayload_t;

    typedef struct packed {
        outVector_t state;
        outMatrix_t cov;
    } outPayload_t;

endpackage

// File: logic/pipeRegister.sv
module pipeRegister #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     upValid,
    output logic     upReady,
    input  payload_t upData,
    output logic     downValid,
    input  logic     downReady,
    output payload_t downData
);

    logic     validReg;
    payload_t dataReg;

    // Free slot now, or the current entry leaves this cycle
    assign upReady = !validReg || downReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            validReg <= 1'b0;
        end else if (upReady) begin
            // Refill or drain in one step
            validReg <= upValid;
        end
    end

    always_ff @(posedge clk) begin
        if (upValid && upReady) begin
            dataReg <= upData;
        end
    end

    assign downValid = validReg;
    assign downData  = dataReg;

endmodule

// File: logic/stateProjector.sv
module stateProjector (
    input  kalmanPkg::inVector_t  stateIn,
    output kalmanPkg::outVector_t stateNext
);

    import kalmanPkg::*;

    // Positions pick up timeStep times their velocity, velocities pass
    for (genvar row = 0; row < stateCount; row++) begin : gRow
        outElem_t acc;

        always_comb begin
            acc = '0;
            for (int k = 0; k < stateCount; k++) begin
                // Zero coefficients fold away at elaboration
                acc = acc + outElem_t'(transitionMatrix[row][k] * stateIn[k]);
            end
        end

        assign stateNext[row] = acc;
    end

endmodule

// File: logic/covarianceProduct.sv
module covarianceProduct (
    input  kalmanPkg::inMatrix_t      covIn,
    output kalmanPkg::productMatrix_t covProduct
);

    import kalmanPkg::*;

    ////////////////////////////////////////////////////////////
    // F * P
    ////////////////////////////////////////////////////////////

    for (genvar row = 0; row < stateCount; row++) begin : gRow
        for (genvar col = 0; col < stateCount; col++) begin : gCol
            productElem_t acc;

            // Row of F against column col of P
            always_comb begin
                acc = '0;
                for (int k = 0; k < stateCount; k++) begin
                    acc = acc + productElem_t'(
                        transitionMatrix[row][k] * covIn[k * stateCount + col]);
                end
            end

            assign covProduct[row * stateCount + col] = acc;
        end
    end

endmodule

// File: logic/covarianceUpdate.sv
module covarianceUpdate (
    input  kalmanPkg::productMatrix_t covProduct,
    output kalmanPkg::outMatrix_t     covNext
);

    import kalmanPkg::*;

    ////////////////////////////////////////////////////////////
    // (F * P) * F' + Q
    ////////////////////////////////////////////////////////////

    for (genvar row = 0; row < stateCount; row++) begin : gRow
        for (genvar col = 0; col < stateCount; col++) begin : gCol
            // Q is diagonal, position terms first
            localparam int noise = (row != col)       ? 0           :
                                   (row < axisCount)  ? posVariance :
                                                        velVariance;
            outElem_t acc;

            // Column col of F' is row col of F
            always_comb begin
                acc = outElem_t'(noise);
                for (int k = 0; k < stateCount; k++) begin
                    acc = acc + outElem_t'(
                        covProduct[row * stateCount + k] * transitionMatrix[col][k]);
                end
            end

            assign covNext[row * stateCount + col] = acc;
        end
    end

endmodule

// File: logic/statePredictor.sv
module statePredictor (
    input  logic                  clk,
    input  logic                  reset,

    // Input side
    input  logic                  inValid,
    output logic                  inReady,
    input  kalmanPkg::inVector_t  stateIn,
    input  kalmanPkg::inMatrix_t  covIn,

    // Output side
    output logic                  outValid,
    input  logic                  outReady,
    output kalmanPkg::outVector_t stateOut,
    output kalmanPkg::outMatrix_t covOut
);

    import kalmanPkg::*;

    outVector_t     stateNext;
    productMatrix_t covProduct;
    outMatrix_t     covNext;

    midPayload_t    midIn;
    midPayload_t    midOut;
    logic           midValid;
    logic           midReady;

    outPayload_t    outIn;
    outPayload_t    outData;

    ////////////////////////////////////////////////////////////
    // Stage one, state projection and F * P
    ////////////////////////////////////////////////////////////

    stateProjector stateProj (
        .stateIn   (stateIn),
        .stateNext (stateNext)
    );

    covarianceProduct covProd (
        .covIn      (covIn),
        .covProduct (covProduct)
    );

    assign midIn.state = stateNext;
    assign midIn.cov   = covProduct;

    pipeRegister #(
        .payload_t (midPayload_t)
    ) midStage (
        .clk       (clk),
        .reset     (reset),
        .upValid   (inValid),
        .upReady   (inReady),
        .upData    (midIn),
        .downValid (midValid),
        .downReady (midReady),
        .downData  (midOut)
    );

    ////////////////////////////////////////////////////////////
    // Stage two, F' product and process noise
    ////////////////////////////////////////////////////////////

    covarianceUpdate covUpd (
        .covProduct (midOut.cov),
        .covNext    (covNext)
    );

    // State is already final after stage one
    assign outIn.state = midOut.state;
    assign outIn.cov   = covNext;

    pipeRegister #(
        .payload_t (outPayload_t)
    ) outStage (
        .clk       (clk),
        .reset     (reset),
        .upValid   (midValid),
        .upReady   (midReady),
        .upData    (outIn),
        .downValid (outValid),
        .downReady (outReady),
        .downData  (outData)
    );

    assign stateOut = outData.state;
    assign covOut   = outData.cov;

endmodule

// File: verif/predictionChecker.sv
module predictionChecker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  logic                  inReady,
    input  kalmanPkg::inVector_t  stateIn,
    input  kalmanPkg::inMatrix_t  covIn,
    input  logic                  outValid,
    input  logic                  outReady,
    input  kalmanPkg::outVector_t stateOut,
    input  kalmanPkg::outMatrix_t covOut,
    output int                    valueErrors,
    output int                    protocolErrors,
    output int                    resultCount,
    output int                    pending
);

    import kalmanPkg::*;

    outVector_t expStateQ [$];
    outMatrix_t expCovQ [$];
    int         acceptQ [$];

    int cycleNo;
    int lastStall;
    int resetEdges;
    int acceptCount;
    int occupancy;

    initial begin
        valueErrors    = 0;
        protocolErrors = 0;
        resultCount    = 0;
        pending        = 0;
        cycleNo        = 0;
        lastStall      = -1;
        resetEdges     = 0;
        acceptCount    = 0;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic void predictRef(
        input  inVector_t  s,
        input  inMatrix_t  p,
        output outVector_t sx,
        output outMatrix_t px
    );
        longint f [stateCount][stateCount];
        longint fp [stateCount][stateCount];
        longint acc;

        // Identity with timeStep linking velocity i+3 to position i
        for (int r = 0; r < stateCount; r++) begin
            for (int c = 0; c < stateCount; c++) begin
                f[r][c] = (r == c) ? 1 : 0;
            end
        end
        for (int i = 0; i < axisCount; i++) begin
            f[i][i + axisCount] = timeStep;
        end

        for (int r = 0; r < stateCount; r++) begin
            acc = 0;
            for (int k = 0; k < stateCount; k++) begin
                acc += f[r][k] * longint'($signed(s[k]));
            end
            sx[r] = acc[outWidth-1:0];
        end

        for (int r = 0; r < stateCount; r++) begin
            for (int c = 0; c < stateCount; c++) begin
                acc = 0;
                for (int k = 0; k < stateCount; k++) begin
                    acc += f[r][k] * longint'($signed(p[k * stateCount + c]));
                end
                fp[r][c] = acc;
            end
        end

        // Times F transposed plus noise on the diagonal only
        for (int r = 0; r < stateCount; r++) begin
            for (int c = 0; c < stateCount; c++) begin
                if (r != c) begin
                    acc = 0;
                end else begin
                    acc = (r < axisCount) ? posVariance : velVariance;
                end
                for (int k = 0; k < stateCount; k++) begin
                    acc += fp[r][k] * f[c][k];
                end
                px[r * stateCount + c] = acc[outWidth-1:0];
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Comparison
    ////////////////////////////////////////////////////////////

    task automatic compareResult();
        outVector_t expState;
        outMatrix_t expCov;
        int         acceptCycle;

        expState    = expStateQ.pop_front();
        expCov      = expCovQ.pop_front();
        acceptCycle = acceptQ.pop_front();

        for (int i = 0; i < stateCount; i++) begin
            if (stateOut[i] !== expState[i]) begin
                $display("FAILED at %0t: state element %0d expected %0d got %0d",
                    $time, i, $signed(expState[i]), $signed(stateOut[i]));
                valueErrors++;
            end
        end
        for (int i = 0; i < matrixSize; i++) begin
            if (covOut[i] !== expCov[i]) begin
                $display("FAILED at %0t: covariance element %0d expected %0d got %0d",
                    $time, i, $signed(expCov[i]), $signed(covOut[i]));
                valueErrors++;
            end
        end

        // Exactly two edges when nothing stalled since acceptance
        if (cycleNo - acceptCycle < 2) begin
            $display("Result at time %0t left the pipeline after only %0d cycles",
                $time, cycleNo - acceptCycle);
            protocolErrors++;
        end else if (lastStall <= acceptCycle && cycleNo - acceptCycle != 2) begin
            $display("Result at time %0t took %0d cycles without any output stall",
                $time, cycleNo - acceptCycle);
            protocolErrors++;
        end
    endtask

    always @(posedge clk) begin
        // Idle outputs during reset and until the first input transfer
        if (resetEdges > 0 && acceptCount == 0) begin
            if (outValid !== 1'b0 || inReady !== 1'b1) begin
                $display("FAILED at %0t: idle pipeline shows outValid %b inReady %b",
                    $time, outValid, inReady);
                protocolErrors++;
            end
        end

        if (reset) begin
            resetEdges++;
        end else begin
            occupancy = expStateQ.size();

            // Input side stalls only with both stages full and blocked
            if (inReady !== !(occupancy >= 2 && !outReady)) begin
                $display("FAILED at %0t: inReady is %b with %0d results in flight",
                    $time, inReady, occupancy);
                protocolErrors++;
            end

            if (outValid && outReady) begin
                if (occupancy == 0) begin
                    $display("Output at time %0t arrived with no input waiting for it",
                        $time);
                    protocolErrors++;
                end else begin
                    compareResult();
                end
                resultCount++;
            end

            if (inValid && inReady) begin
                outVector_t nextState;
                outMatrix_t nextCov;
                predictRef(stateIn, covIn, nextState, nextCov);
                expStateQ.push_back(nextState);
                expCovQ.push_back(nextCov);
                acceptQ.push_back(cycleNo);
                acceptCount++;
            end
        end

        if (!outReady) begin
            lastStall = cycleNo;
        end
        cycleNo++;
        pending = expStateQ.size();
    end

endmodule

// File: verif/statePredictorTb.sv
module statePredictorTb;

    import kalmanPkg::*;

    localparam int numTransactions = 200;
    localparam int streamCount     = 100;
    // Four cycles per transaction at worst, plus reset and drain
    localparam int cycleLimit      = 4 * numTransactions + 100;

    logic       clk;
    logic       reset;
    logic       inValid;
    logic       inReady;
    inVector_t  stateIn;
    inMatrix_t  covIn;
    logic       outValid;
    logic       outReady;
    outVector_t stateOut;
    outMatrix_t covOut;

    int valueErrors;
    int protocolErrors;
    int resultCount;
    int pending;
    int leftover;

    int seed;
    int cycleCount;
    // 0 streaming, 1 random stalls, 2 drain
    int phase;

    inVector_t stateStim [numTransactions];
    inMatrix_t covStim [numTransactions];
    int        gapStim [numTransactions];
    logic      stallPattern [cycleLimit];

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    statePredictor uut (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .stateIn  (stateIn),
        .covIn    (covIn),
        .outValid (outValid),
        .outReady (outReady),
        .stateOut (stateOut),
        .covOut   (covOut)
    );

    predictionChecker predCheck (
        .clk            (clk),
        .reset          (reset),
        .inValid        (inValid),
        .inReady        (inReady),
        .stateIn        (stateIn),
        .covIn          (covIn),
        .outValid       (outValid),
        .outReady       (outReady),
        .stateOut       (stateOut),
        .covOut         (covOut),
        .valueErrors    (valueErrors),
        .protocolErrors (protocolErrors),
        .resultCount    (resultCount),
        .pending        (pending)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic fillStimulus();
        for (int t = 0; t < numTransactions; t++) begin
            for (int i = 0; i < stateCount; i++) begin
                stateStim[t][i] = inElem_t'($random(seed));
            end
            for (int i = 0; i < matrixSize; i++) begin
                covStim[t][i] = inElem_t'($random(seed));
            end
            gapStim[t] = (t < streamCount) ? 0 : $unsigned($random(seed)) % 3;
        end
        // Pure noise diagonal expected here
        covStim[0] = '0;
        for (int c = 0; c < cycleLimit; c++) begin
            stallPattern[c] = ($random(seed) & 1) == 1;
        end
    endtask

    task automatic sendVector(input int idx);
        inValid <= 1'b1;
        stateIn <= stateStim[idx];
        covIn   <= covStim[idx];
        @(posedge clk);
        while (inReady !== 1'b1) begin
            @(posedge clk);
        end
        if (gapStim[idx] > 0) begin
            inValid <= 1'b0;
            repeat (gapStim[idx]) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (phase == 1) begin
            outReady <= stallPattern[cycleCount % cycleLimit];
        end else begin
            outReady <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d results received",
                cycleLimit, resultCount, numTransactions);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed       = 32'hfd2e54f5;
        cycleCount = 0;
        phase      = 0;
        reset      = 1'b1;
        inValid    = 1'b0;
        outReady   = 1'b1;
        stateIn    = '0;
        covIn      = '0;
        leftover   = 0;
        fillStimulus();

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int t = 0; t < numTransactions; t++) begin
            if (t == streamCount) begin
                phase <= 1;
            end
            sendVector(t);
        end
        inValid <= 1'b0;
        phase   <= 2;

        do begin
            @(negedge clk);
        end while (resultCount < numTransactions);
        // A few idle cycles to catch repeated outputs
        repeat (4) @(negedge clk);

        leftover = pending;
        if (leftover != 0) begin
            $display("%0d expected results were still waiting at the end of the run",
                leftover);
        end
        $display("Errors: values %0d, protocol %0d, left over %0d, results %0d",
            valueErrors, protocolErrors, leftover, resultCount);
        if (valueErrors + protocolErrors + leftover == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/kalmanPkg.sv
logic/pipeRegister.sv
logic/stateProjector.sv
logic/covarianceProduct.sv
logic/covarianceUpdate.sv
logic/statePredictor.sv
verif/predictionChecker.sv
verif/statePredictorTb.sv

// File: Bender.yml
package:
  name: state_predictor

sources:
  - logic/kalmanPkg.sv
  - logic/pipeRegister.sv
  - logic/stateProjector.sv
  - logic/covarianceProduct.sv
  - logic/covarianceUpdate.sv
  - logic/statePredictor.sv
  - target: test
    files:
      - verif/predictionChecker.sv
      - verif/statePredictorTb.sv
